// ==== miniCpuCore.f ====
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/memUnit.sv
hdl/execCtrl.sv
hdl/miniCpuCore.sv
tb/miniCpuCore_sva.sv
tb/miniCpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
        --top-module miniCpuTb -f miniCpuCore.f -o simv || exit 1
output="$(./obj_dir/simv 2>&1)"
echo "$output"
echo "$output" | grep -qx "test passed" && exit 0 || exit 1

// ==== tb/miniCpuTb.sv ====
`timescale 1ns/1ps

module miniCpuTb import cpuPkg::*; ();

        localparam opcodeE aluOps [12] = '{opAdd, opSub, opAnd, opOr, opXor, opNor,
                                           opShl, opShr, opShra, opRol, opRor, opNot};

        logic        clk;
        logic        rstN;
        apbReqT      apbReq;
        apbRspT      apbRsp;
        logic [31:0] lfsr = 32'h57fe82fa;
        logic [31:0] regModel [regCount];
        logic [31:0] memModel [memWords];
        logic [31:0] lastInstr;                // Expected read of instrAddr
        int          nChecks, nErrors, errMark;

        miniCpuCore u_dut (.clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp));

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // Fibonacci LFSR with taps 32 22 2 1, one step per bit
        function automatic logic [31:0] randBits(input int n);
                logic [31:0] v;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
                        v    = {v[30:0], lfsr[0]};
                end
                return v;
        endfunction

        function automatic logic [31:0] mkInstr(input logic [4:0] op, input logic [3:0] ra,
                                                input logic [3:0] rb, input logic [18:0] tail);
                return {op, ra, rb, tail};
        endfunction

        function automatic logic [9:0] regAddr(input logic [3:0] i);
                return regBase + {4'b0, i, 2'b00};
        endfunction

        function automatic logic [9:0] memAddr(input logic [6:0] i);
                return memBase + {1'b0, i, 2'b00};
        endfunction

        // Base plus sign-extended c, modulo the memory depth
        function automatic logic [6:0] effAddr(input logic [31:0] base, input logic [18:0] c);
                logic [31:0] sum;
                sum = base + {{13{c[18]}}, c};
                return sum[6:0];
        endfunction

        // Shifts and rotates done one bit at a time
        function automatic logic [31:0] aluModel(input logic [4:0] op, input logic [31:0] a,
                                                 input logic [31:0] b);
                logic [31:0] v;
                v = a;
                case (op)
                        opAdd:   v = a + b;
                        opSub:   v = a - b;
                        opAnd:   v = a & b;
                        opOr:    v = a | b;
                        opXor:   v = a ^ b;
                        opNor:   v = ~(a | b);
                        opNot:   v = ~a;
                        opShl:   repeat (b[4:0]) v = {v[30:0], 1'b0};
                        opShr:   repeat (b[4:0]) v = {1'b0, v[31:1]};
                        opShra:  repeat (b[4:0]) v = {v[31], v[31:1]};
                        opRol:   repeat (b[4:0]) v = {v[30:0], v[31]};
                        opRor:   repeat (b[4:0]) v = {v[0], v[31:1]};
                        default: v = '0;
                endcase
                return v;
        endfunction

        task automatic abortRun(input string why);
                $display("%0t: %s", $time, why);
                $display("test failed");
                $finish;
        endtask

        task automatic stepToDrive();
                @(posedge clk);
                #1;
        endtask

        task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
                nChecks++;
                assert (got === exp) else begin
                        nErrors++;
                        $display("error %0t: %s gave %h, expected %h", $time, what, got, exp);
                end
        endtask

        task automatic endTest(input string name);
                $display("%s finished with %0d errors", name, nErrors - errMark);
                errMark = nErrors;
        endtask

        // One APB transfer, setup then access cycles until pready
        task automatic apbXfer(input logic write, input logic [9:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
                int waitCycles;
                stepToDrive();
                apbReq.psel    = 1'b1;
                apbReq.penable = 1'b0;
                apbReq.pwrite  = write;
                apbReq.paddr   = addr;
                apbReq.pwdata  = wdata;
                stepToDrive();
                apbReq.penable = 1'b1;
                waitCycles = 0;
                while (!apbRsp.pready && waitCycles < 20) begin
                        stepToDrive();
                        waitCycles++;
                end
                if (!apbRsp.pready) begin
                        abortRun($sformatf("no pready within 20 cycles at address %h", addr));
                end else begin
                        rdata = apbRsp.prdata;
                        err   = apbRsp.pslverr;
                        stepToDrive();
                        apbReq.psel    = 1'b0;
                        apbReq.penable = 1'b0;
                end
        endtask

        task automatic writeWord(input logic [9:0] addr, input logic [31:0] data,
                                 input logic expErr);
                logic [31:0] rd;
                logic        err;
                apbXfer(1'b1, addr, data, rd, err);
                checkEq($sformatf("pslverr of write to %h", addr), 32'(err), 32'(expErr));
        endtask

        task automatic readCheck(input logic [9:0] addr, input logic [31:0] exp,
                                 input logic expErr);
                logic [31:0] rd;
                logic        err;
                apbXfer(1'b0, addr, '0, rd, err);
                checkEq($sformatf("pslverr of read from %h", addr), 32'(err), 32'(expErr));
                if (!expErr) begin
                        checkEq($sformatf("read from %h", addr), rd, exp);
                end
        endtask

        task automatic setReg(input logic [3:0] i, input logic [31:0] v);
                writeWord(regAddr(i), v, 1'b0);
                regModel[i] = v;
        endtask

        task automatic setMem(input logic [6:0] i, input logic [31:0] v);
                writeWord(memAddr(i), v, 1'b0);
                memModel[i] = v;
        endtask

        task automatic issue(input logic [31:0] instr, input logic expErr);
                writeWord(instrAddr, instr, expErr);
                if (!expErr) begin
                        lastInstr = instr;
                end
        endtask

        task automatic sweepAll();
                for (int i = 0; i < regCount; i++) begin
                        readCheck(regAddr(4'(i)), regModel[i], 1'b0);
                end
                for (int i = 0; i < memWords; i++) begin
                        readCheck(memAddr(7'(i)), memModel[i], 1'b0);
                end
        endtask

        initial begin
                logic [3:0]  ra, rb, rc;
                logic [18:0] c;
                logic [6:0]  addr;
                rstN      = 1'b0;
                apbReq    = '0;
                nChecks   = 0;
                nErrors   = 0;
                errMark   = 0;
                lastInstr = '0;
                for (int i = 0; i < regCount; i++) begin
                        regModel[i] = '0;
                end
                for (int i = 0; i < memWords; i++) begin
                        memModel[i] = '0;
                end
                repeat (16) @(posedge clk);
                #1 rstN = 1'b1;

                for (int i = 0; i < regCount; i++) begin // R0 included
                        setReg(4'(i), randBits(32));
                end
                for (int i = 0; i < 8; i++) begin
                        setMem(7'(randBits(7)), randBits(32));
                end
                sweepAll();
                endTest("register and memory access");

                foreach (aluOps[k]) begin
                        ra = 4'(randBits(4));
                        rb = 4'(randBits(4));
                        rc = 4'(randBits(4));
                        setReg(rb, randBits(32));
                        setReg(rc, randBits(32));
                        issue(mkInstr(aluOps[k], ra, rb, {rc, 15'd0}), 1'b0);
                        regModel[ra] = aluModel(aluOps[k], regModel[rb], regModel[rc]);
                        readCheck(regAddr(ra), regModel[ra], 1'b0);
                end
                readCheck(instrAddr, lastInstr, 1'b0);
                endTest("ALU operations");

                setReg(4'd1, 32'd5);                     // Reference case, 5 + 0x45
                setMem(7'h4A, randBits(32));
                issue(mkInstr(opLd, 4'd2, 4'd1, 19'h45), 1'b0);
                regModel[2] = memModel[7'h4A];
                readCheck(regAddr(4'd2), regModel[2], 1'b0);
                setReg(4'd0, randBits(32) | 32'h40);      // Must not act as a base
                setMem(7'd125, randBits(32));
                issue(mkInstr(opLd, 4'd3, 4'd0, 19'h7FFFD), 1'b0); // c = -3
                regModel[3] = memModel[7'd125];
                readCheck(regAddr(4'd3), regModel[3], 1'b0);
                endTest("load");

                setReg(4'd4, randBits(32));
                setReg(4'd5, randBits(32));
                c    = 19'(randBits(19));
                addr = effAddr(regModel[5], c);
                issue(mkInstr(opSt, 4'd4, 4'd5, c), 1'b0);
                memModel[addr] = regModel[4];
                readCheck(memAddr(addr), memModel[addr], 1'b0);
                issue(mkInstr(opLd, 4'd6, 4'd5, c), 1'b0);
                regModel[6] = memModel[addr];
                readCheck(regAddr(4'd6), regModel[6], 1'b0);
                endTest("store then load");

                issue(mkInstr(5'd3, 4'd7, 4'd1, {4'd2, 15'd0}), 1'b1);  // mul, not supported
                issue(mkInstr(5'd20, 4'd7, 4'd1, {4'd2, 15'd0}), 1'b1);
                writeWord(10'h240, randBits(32), 1'b1);
                readCheck(10'h3F0, '0, 1'b1);
                sweepAll();
                readCheck(instrAddr, lastInstr, 1'b0);
                endTest("errors");

                $display("%0d checks, %0d errors", nChecks, nErrors);
                if (nErrors == 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        end

endmodule

// ==== tb/miniCpuCore_sva.sv ====
`timescale 1ns/1ps

module miniCpuCoreSva import cpuPkg::*; (
        input logic   clk,
        input logic   rstN,
        input apbReqT apbReq,
        input apbRspT apbRsp,
        input wbT     wb
);

        logic regWrite;
        logic instrXfer;

        // Direct register writes use the write port in their setup cycle
        assign regWrite  = apbReq.psel && !apbReq.penable && apbReq.pwrite &&
                           apbReq.paddr >= regBase && apbReq.paddr < regBase + 10'h40;
        assign instrXfer = apbReq.psel && apbReq.penable && apbReq.pwrite &&
                           apbReq.paddr == instrAddr;

        errWithReady: assert property (@(posedge clk) disable iff (!rstN)
                apbRsp.pslverr |-> apbRsp.pready)
                else $error("pslverr high without pready");

        readyInAccess: assert property (@(posedge clk) disable iff (!rstN)
                apbRsp.pready |-> apbReq.psel && apbReq.penable)
                else $error("pready high outside an access cycle");

        wbInTransfer: assert property (@(posedge clk) disable iff (!rstN)
                wb.valid |-> instrXfer || regWrite)
                else $error("register write outside an instruction or register transfer");

endmodule

bind miniCpuCore miniCpuCoreSva u_sva (
        .clk    (clk),
        .rstN   (rstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .wb     (wb)
);

// ==== hdl/miniCpuCore.sv ====
`timescale 1ns/1ps

module miniCpuCore import cpuPkg::*; (
        input  logic   clk,
        input  logic   rstN,
        input  apbReqT apbReq,
        output apbRspT apbRsp
);

        aluReqT             aluReq;
        memReqT             memReq;
        wbT                 wb;
        logic [dataW-1:0]   aluY, memQ;
        logic [dataW-1:0]   rdA, rdB;
        logic [regIdxW-1:0] rdIdxA, rdIdxB;

        // APB decode, step sequencer and writeback select
        execCtrl u_execCtrl (
                .clk    (clk),
                .rstN   (rstN),
                .apbReq (apbReq),
                .apbRsp (apbRsp),
                .aluReq (aluReq),
                .memReq (memReq),
                .aluY   (aluY),
                .memQ   (memQ),
                .rdIdxA (rdIdxA),
                .rdIdxB (rdIdxB),
                .rdA    (rdA),
                .rdB    (rdB),
                .wb     (wb)
        );

        regFile u_regFile (
                .clk    (clk),
                .rstN   (rstN),
                .rdIdxA (rdIdxA),
                .rdIdxB (rdIdxB),
                .rdA    (rdA),
                .rdB    (rdB),
                .wb     (wb)
        );

        aluUnit u_aluUnit (.clk(clk), .rstN(rstN), .req(aluReq), .y(aluY));

        memUnit u_memUnit (.clk(clk), .rstN(rstN), .req(memReq), .q(memQ)); // Data memory

endmodule

// ==== hdl/execCtrl.sv ====
`timescale 1ns/1ps

module execCtrl import cpuPkg::*; (
        input  logic               clk,
        input  logic               rstN,
        input  apbReqT             apbReq,
        output apbRspT             apbRsp,
        output aluReqT             aluReq,
        output memReqT             memReq,
        input  logic [dataW-1:0]   aluY,
        input  logic [dataW-1:0]   memQ,
        output logic [regIdxW-1:0] rdIdxA,
        output logic [regIdxW-1:0] rdIdxB,
        input  logic [dataW-1:0]   rdA,
        input  logic [dataW-1:0]   rdB,
        output wbT                 wb
);

        typedef enum logic [1:0] {sIdle, sMemRd, sExec, sWb} stateE;

        stateE               state;
        instrT               instrReg;   // Also read back at instrAddr
        instrT               newInstr;
        logic                setup, isMem, isReg, isInstr, opDefined, err;
        logic                isAluOp;
        logic [apbAddrW-1:0] memOff, regOff;
        logic [memAddrW-1:0] memIdx;
        logic [regIdxW-1:0]  regIdx;

        assign setup    = apbReq.psel && !apbReq.penable;
        assign newInstr = apbReq.pwdata;

        // Address decode
        assign memOff  = apbReq.paddr - memBase;
        assign regOff  = apbReq.paddr - regBase;
        assign memIdx  = memOff[memAddrW+1:2];
        assign regIdx  = regOff[regIdxW+1:2];
        assign isMem   = apbReq.paddr >= memBase && apbReq.paddr < memBase + memWords * 4;
        assign isReg   = apbReq.paddr >= regBase && apbReq.paddr < regBase + regCount * 4;
        assign isInstr = apbReq.paddr[apbAddrW-1:2] == instrAddr[apbAddrW-1:2];

        assign opDefined = newInstr.op inside {opNop, opAdd, opSub, opShr, opShl, opShra,
                                               opRor, opRol, opAnd, opOr, opNot, opXor,
                                               opNor, opLd, opSt};
        assign err = !(isMem || isReg || isInstr) ||
                     (isInstr && apbReq.pwrite && !opDefined);

        assign isAluOp = instrReg.op inside {opAdd, opSub, opShr, opShl, opShra, opRor,
                                             opRol, opAnd, opOr, opNot, opXor, opNor};

        always_comb begin
                // a = Rb; b = Rc, or Ra as store data
                rdIdxA = (state == sIdle) ? regIdx : instrReg.rb;
                rdIdxB = (instrReg.op == opSt) ? instrReg.ra : instrReg.tail.r.rc;
                aluReq       = '0;
                aluReq.op    = instrReg.op;
                aluReq.a     = rdA;
                aluReq.b     = rdB;
                memReq       = '0;
                wb           = '0;
                wb.index     = instrReg.ra;
                case (state)
                        sIdle: if (setup && !err) begin
                                if (isMem) begin  // Direct access, zero base
                                        memReq.valid  = 1'b1;
                                        memReq.write  = apbReq.pwrite;
                                        memReq.offset = dataW'(memIdx);
                                        memReq.wdata  = apbReq.pwdata;
                                end
                                if (isReg && apbReq.pwrite) begin
                                        wb.valid = 1'b1;
                                        wb.index = regIdx;
                                        wb.data  = apbReq.pwdata;
                                end
                        end
                        sExec: begin
                                aluReq.valid = isAluOp;
                                if (instrReg.op inside {opLd, opSt}) begin
                                        memReq.valid  = 1'b1;
                                        memReq.write  = instrReg.op == opSt;
                                        memReq.base   = (instrReg.rb == '0) ? '0 : rdA; // R0 base is zero
                                        memReq.offset = {{13{instrReg.tail.c[18]}}, instrReg.tail.c};
                                        memReq.wdata  = rdB;
                                end
                        end
                        sWb: begin
                                wb.valid = instrReg.op != opNop;
                                wb.data  = (instrReg.op == opLd) ? memQ : aluY;
                        end
                        default: ;
                endcase
        end

        // Response is registered, pready lasts one cycle
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        state    <= sIdle;
                        instrReg <= '0;
                        apbRsp   <= '0;
                end else begin
                        apbRsp.pready  <= 1'b0;
                        apbRsp.pslverr <= 1'b0;
                        case (state)
                                sIdle: if (setup) begin
                                        if (err) begin
                                                apbRsp.pready  <= 1'b1;
                                                apbRsp.pslverr <= 1'b1;
                                        end else if (isMem && !apbReq.pwrite) begin
                                                state <= sMemRd;
                                        end else if (isInstr && apbReq.pwrite) begin
                                                instrReg <= newInstr;
                                                state    <= sExec;
                                        end else begin
                                                apbRsp.pready <= 1'b1;
                                                if (!apbReq.pwrite) begin
                                                        apbRsp.prdata <= isReg ? rdA : instrReg;
                                                end
                                        end
                                end
                                sMemRd: begin
                                        apbRsp.prdata <= memQ;
                                        apbRsp.pready <= 1'b1;
                                        state         <= sIdle;
                                end
                                sExec: begin
                                        if (instrReg.op == opSt) begin // Store done once memory written
                                                apbRsp.pready <= 1'b1;
                                                state         <= sIdle;
                                        end else begin
                                                state <= sWb;
                                        end
                                end
                                sWb: begin
                                        apbRsp.pready <= 1'b1;
                                        state         <= sIdle;
                                end
                                default: state <= sIdle;
                        endcase
                end
        end

endmodule

// ==== hdl/memUnit.sv ====
`timescale 1ns/1ps

module memUnit import cpuPkg::*; (
        input  logic             clk,
        input  logic             rstN,
        input  memReqT           req,
        output logic [dataW-1:0] q
);

        logic [dataW-1:0]    mem [memWords];
        logic [dataW-1:0]    sum;
        logic [memAddrW-1:0] wordAddr;

        // Effective address, wraps modulo the memory depth
        assign sum      = req.base + req.offset;
        assign wordAddr = sum[memAddrW-1:0];

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < memWords; i++) begin
                                mem[i] <= '0;
                        end
                        q <= '0;
                end else if (req.valid) begin
                        if (req.write) begin
                                mem[wordAddr] <= req.wdata;
                        end else begin
                                q <= mem[wordAddr]; // Registered read data
                        end
                end
        end

endmodule

// ==== hdl/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit import cpuPkg::*; (
        input  logic             clk,
        input  logic             rstN,
        input  aluReqT           req,
        output logic [dataW-1:0] y
);

        logic [4:0]         sh;
        logic [2*dataW-1:0] rotL;
        logic [2*dataW-1:0] rotR;
        logic [dataW-1:0]   result;

        assign sh   = req.b[4:0];              // Shift amount from low bits of b
        assign rotL = {req.a, req.a} << sh;
        assign rotR = {req.a, req.a} >> sh;

        always_comb begin
                case (req.op)
                        opAdd:   result = req.a + req.b;
                        opSub:   result = req.a - req.b;
                        opAnd:   result = req.a & req.b;
                        opOr:    result = req.a | req.b;
                        opXor:   result = req.a ^ req.b;
                        opNor:   result = ~(req.a | req.b);
                        opNot:   result = ~req.a;            // b ignored
                        opShl:   result = req.a << sh;
                        opShr:   result = req.a >> sh;
                        opShra:  result = $signed(req.a) >>> sh; // Sign bit kept
                        opRol:   result = rotL[2*dataW-1:dataW];
                        opRor:   result = rotR[dataW-1:0];
                        default: result = '0;
                endcase
        end

        // Result appears one cycle after the request
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        y <= '0;
                end else if (req.valid) begin
                        y <= result;
                end
        end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
        input  logic               clk,
        input  logic               rstN,
        input  logic [regIdxW-1:0] rdIdxA,
        input  logic [regIdxW-1:0] rdIdxB,
        output logic [dataW-1:0]   rdA,
        output logic [dataW-1:0]   rdB,
        input  wbT                 wb
);

        logic [dataW-1:0] regs [regCount];

        // Both read ports are combinational
        assign rdA = regs[rdIdxA];
        assign rdB = regs[rdIdxB];

        // R0 is an ordinary register here
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < regCount; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wb.valid) begin
                        regs[wb.index] <= wb.data;
                end
        end

endmodule

// ==== hdl/cpuPkg.sv ====
package cpuPkg;

        localparam int dataW    = 32;
        localparam int regCount = 16;
        localparam int memWords = 128;
        localparam int regIdxW  = $clog2(regCount);
        localparam int memAddrW = $clog2(memWords);
        localparam int apbAddrW = 10;

        // APB byte address map
        localparam logic [apbAddrW-1:0] memBase   = 10'h000; // 128 words, 0x000-0x1FC
        localparam logic [apbAddrW-1:0] regBase   = 10'h200; // R0-R15, 0x200-0x23C
        localparam logic [apbAddrW-1:0] instrAddr = 10'h300; // Issue / last issued

        // Codes 3 and 4 (mul, div) are not implemented
        typedef enum logic [4:0] {
                opNop  = 5'd0,
                opAdd  = 5'd1,
                opSub  = 5'd2,
                opShr  = 5'd5,
                opShl  = 5'd6,
                opShra = 5'd7,
                opRor  = 5'd8,
                opRol  = 5'd9,
                opAnd  = 5'd10,
                opOr   = 5'd11,
                opNot  = 5'd12,
                opXor  = 5'd13,
                opNor  = 5'd14,
                opLd   = 5'd16,
                opSt   = 5'd17
        } opcodeE;

        typedef struct packed {
                logic [regIdxW-1:0] rc;
                logic [14:0]        rsvd;
        } regTailT;

        // Low 19 bits hold either rc or the constant c of ld/st
        typedef union packed {
                logic [18:0] c;
                regTailT     r;
        } instrTailT;

        typedef struct packed {
                opcodeE             op;   // [31:27]
                logic [regIdxW-1:0] ra;   // [26:23]
                logic [regIdxW-1:0] rb;   // [22:19]
                instrTailT          tail; // [18:0]
        } instrT;

        typedef struct packed {
                logic                psel;
                logic                penable;
                logic                pwrite;
                logic [apbAddrW-1:0] paddr;
                logic [dataW-1:0]    pwdata;
        } apbReqT;

        typedef struct packed {
                logic [dataW-1:0] prdata;
                logic             pready;
                logic             pslverr;
        } apbRspT;

        typedef struct packed {
                logic             valid;
                opcodeE           op;
                logic [dataW-1:0] a;
                logic [dataW-1:0] b;
        } aluReqT;

        typedef struct packed {
                logic             valid;
                logic             write;
                logic [dataW-1:0] base;
                logic [dataW-1:0] offset;
                logic [dataW-1:0] wdata;
        } memReqT;

        typedef struct packed {
                logic               valid;
                logic [regIdxW-1:0] index;
                logic [dataW-1:0]   data;
        } wbT;

endpackage
